// ==== common/rename_pkg.sv ====
package rename_pkg;

    // architectural register file
    localparam int ARF_DEPTH = 32;
    localparam int ARF_ID_W  = $clog2(ARF_DEPTH);
    localparam int DATA_W    = 32;   // register data, also pc width

    // reorder buffer
    localparam int ROB_DEPTH = 64;
    localparam int ROB_ID_W  = $clog2(ROB_DEPTH);
    localparam int CNT_W     = ROB_ID_W + 1;   // occupancy reaches ROB_DEPTH

    // keep headroom for one more two-wide bundle in flight
    localparam int ROB_LIMIT = 60;

    // bundle shape
    localparam int N_SRC = 4;   // two sources per slot
    localparam int N_DST = 2;   // one destination per slot
    localparam int OP_W  = 8;   // opaque operation field

    // rename table entry
    // check bit tells a fresh speculative mapping apart from the
    // committed one even when the rob id has wrapped around
    typedef struct packed {
        logic                check;
        logic [ROB_ID_W-1:0] rob_id;
    } rat_entry_t;

endpackage

// ==== hdl/rob_alloc.sv ====
module rob_alloc import rename_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               c_flush_i,
    input  logic                               d_valid_i,
    input  logic [N_DST-1:0]                   d_slot_valid_i,
    input  logic                               p_ready_i,
    input  logic [N_DST-1:0]                   c_retire_i,
    output logic                               d_ready_o,
    output logic [N_DST-1:0]                   issue_o,
    output logic [N_DST-1:0][ROB_ID_W-1:0]     rob_id_o
);

    logic [CNT_W-1:0]    cnt_q;
    logic [CNT_W-1:0]    cnt_d;
    logic [ROB_ID_W-1:0] ptr0_q;
    logic [ROB_ID_W-1:0] ptr1_q;
    logic                avail_q;
    logic [1:0]          n_issue;
    logic [1:0]          n_retire;

    assign d_ready_o = avail_q & ~c_flush_i & p_ready_i;

    // one strobe per slot, the only place the handshake is formed
    assign issue_o = d_slot_valid_i & {N_DST{d_valid_i & d_ready_o}};

    assign n_issue  = {1'b0, issue_o[0]} + {1'b0, issue_o[1]};
    assign n_retire = {1'b0, c_retire_i[0]} + {1'b0, c_retire_i[1]};
    assign cnt_d    = cnt_q + CNT_W'(n_issue) - CNT_W'(n_retire);

    assign rob_id_o[0] = ptr0_q;
    assign rob_id_o[1] = ptr1_q;

    always_ff @(posedge clk) begin
        if (rst_i || c_flush_i) begin
            cnt_q   <= '0;
            ptr0_q  <= '0;
            ptr1_q  <= ROB_ID_W'(1);
            avail_q <= 1'b1;
        end else begin
            cnt_q   <= cnt_d;
            ptr0_q  <= ptr0_q + ROB_ID_W'(n_issue);   // wraps at ROB_DEPTH
            ptr1_q  <= ptr1_q + ROB_ID_W'(n_issue);
            // lags the counter by a cycle
            avail_q <= (cnt_q <= CNT_W'(ROB_LIMIT));
        end
    end

endmodule

// ==== rename/spec_rat.sv ====
module spec_rat import rename_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               c_flush_i,
    input  logic [N_SRC-1:0][ARF_ID_W-1:0]     src_id_i,
    input  logic [N_DST-1:0][ARF_ID_W-1:0]     dst_id_i,
    input  logic [N_DST-1:0]                   w_reg_i,
    input  logic [N_DST-1:0]                   issue_i,
    input  logic [N_DST-1:0][ROB_ID_W-1:0]     rob_id_i,
    input  logic [N_DST-1:0]                   cw_check_i,
    output rat_entry_t [N_SRC-1:0]             src_map_o,
    output logic [N_DST-1:0]                   new_check_o
);

    rat_entry_t              tbl [ARF_DEPTH];
    logic       [N_DST-1:0]  we;
    rat_entry_t [N_DST-1:0]  new_ent;

    // new mapping always differs from the committed one
    assign new_check_o = ~cw_check_i;

    always_comb begin
        for (int i = 0; i < N_DST; i++) begin
            we[i]             = issue_i[i] & w_reg_i[i] & (|dst_id_i[i]);
            new_ent[i].check  = new_check_o[i];
            new_ent[i].rob_id = rob_id_i[i];
        end
    end

    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            src_map_o[i] = tbl[src_id_i[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || c_flush_i) begin
            for (int r = 0; r < ARF_DEPTH; r++) begin
                tbl[r] <= '0;
            end
        end else begin
            // slot 1 is younger, wins on the same register
            for (int i = 0; i < N_DST; i++) begin
                if (we[i]) begin
                    tbl[dst_id_i[i]] <= new_ent[i];
                end
            end
        end
    end

endmodule

// ==== rename/commit_rat.sv ====
module commit_rat import rename_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst_i,
    input  logic                                   c_flush_i,
    input  logic [N_SRC+N_DST-1:0][ARF_ID_W-1:0]   rd_id_i,
    input  logic [N_DST-1:0]                       c_retire_i,
    input  logic [N_DST-1:0]                       c_w_valid_i,
    input  logic [N_DST-1:0][ARF_ID_W-1:0]         c_arf_id_i,
    input  logic [N_DST-1:0][ROB_ID_W-1:0]         c_rob_id_i,
    input  logic [N_DST-1:0]                       c_check_i,
    output rat_entry_t [N_SRC+N_DST-1:0]           rd_map_o
);

    localparam int N_RD = N_SRC + N_DST;

    rat_entry_t              tbl [ARF_DEPTH];
    logic       [N_DST-1:0]  we;
    rat_entry_t [N_DST-1:0]  wr_ent;

    always_comb begin
        for (int j = 0; j < N_DST; j++) begin
            we[j]            = c_retire_i[j] & c_w_valid_i[j] & (|c_arf_id_i[j]);
            wr_ent[j].check  = c_check_i[j];
            wr_ent[j].rob_id = c_rob_id_i[j];
        end
    end

    // read with bypass of this cycle's retire writes
    always_comb begin
        for (int i = 0; i < N_RD; i++) begin
            rd_map_o[i] = tbl[rd_id_i[i]];
            for (int j = 0; j < N_DST; j++) begin
                if (we[j] && c_arf_id_i[j] == rd_id_i[i]) begin
                    rd_map_o[i] = wr_ent[j];   // later slot overrides
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || c_flush_i) begin
            for (int r = 0; r < ARF_DEPTH; r++) begin
                tbl[r] <= '0;
            end
        end else begin
            for (int j = 0; j < N_DST; j++) begin
                if (we[j]) begin
                    tbl[c_arf_id_i[j]] <= wr_ent[j];
                end
            end
        end
    end

endmodule

// ==== hdl/arf.sv ====
module arf import rename_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic [N_SRC-1:0][ARF_ID_W-1:0]     rd_id_i,
    input  logic [N_DST-1:0]                   c_retire_i,
    input  logic [N_DST-1:0]                   c_w_valid_i,
    input  logic [N_DST-1:0][ARF_ID_W-1:0]     c_arf_id_i,
    input  logic [N_DST-1:0][DATA_W-1:0]       c_data_i,
    output logic [N_SRC-1:0][DATA_W-1:0]       rd_data_o
);

    logic [DATA_W-1:0] regs [ARF_DEPTH];
    logic [N_DST-1:0]  we;

    // r0 is never written
    assign we = c_retire_i & c_w_valid_i & {|c_arf_id_i[1], |c_arf_id_i[0]};

    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            rd_data_o[i] = regs[rd_id_i[i]];
            for (int j = 0; j < N_DST; j++) begin
                if (we[j] && c_arf_id_i[j] == rd_id_i[i]) begin
                    rd_data_o[i] = c_data_i[j];
                end
            end
            if (rd_id_i[i] == '0) begin
                rd_data_o[i] = '0;
            end
        end
    end

    // survives flush, only reset clears it
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int r = 0; r < ARF_DEPTH; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int j = 0; j < N_DST; j++) begin
                if (we[j]) begin
                    regs[c_arf_id_i[j]] <= c_data_i[j];
                end
            end
        end
    end

endmodule

// ==== rename/rename_out.sv ====
module rename_out import rename_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               c_flush_i,
    input  logic                               p_ready_i,
    input  logic [N_DST-1:0]                   d_slot_valid_i,
    input  logic [DATA_W-1:0]                  d_pc_i,
    input  logic [OP_W-1:0]                    d_op_i,
    input  logic [N_DST-1:0][ARF_ID_W-1:0]     d_dst_id_i,
    input  logic [N_DST-1:0]                   d_w_reg_i,
    input  logic [N_SRC-1:0]                   d_reg_need_i,
    input  logic [N_DST-1:0][ROB_ID_W-1:0]     rob_id_i,
    input  rat_entry_t [N_SRC-1:0]             src_map_i,
    input  rat_entry_t [N_SRC-1:0]             commit_src_map_i,
    input  logic [N_DST-1:0]                   new_check_i,
    input  logic [N_SRC-1:0][DATA_W-1:0]       src_data_i,
    output logic                               p_valid_o,
    output logic [N_DST-1:0]                   p_slot_valid_o,
    output logic [DATA_W-1:0]                  p_pc_o,
    output logic [OP_W-1:0]                    p_op_o,
    output logic [N_DST-1:0][ARF_ID_W-1:0]     p_dst_id_o,
    output logic [N_DST-1:0][ROB_ID_W-1:0]     p_dst_rob_o,
    output logic [N_SRC-1:0][ROB_ID_W-1:0]     p_src_rob_o,
    output logic [N_SRC-1:0][DATA_W-1:0]       p_src_data_o,
    output logic [N_SRC-1:0]                   p_data_valid_o,
    output logic [N_DST-1:0]                   p_check_o,
    output logic [N_DST-1:0]                   p_w_reg_o
);

    logic [N_SRC-1:0]                src_ready;
    logic [N_SRC-1:0][ROB_ID_W-1:0]  src_rob;

    // always presenting, slot valid bits tell what is real
    assign p_valid_o = 1'b1;

    // operand is in the arf once no younger writer is in flight
    always_comb begin
        for (int i = 0; i < N_SRC; i++) begin
            src_ready[i] = ~d_reg_need_i[i] | (src_map_i[i] == commit_src_map_i[i]);
            src_rob[i]   = src_map_i[i].rob_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || c_flush_i) begin
            p_slot_valid_o <= '0;
            p_pc_o         <= '0;
            p_op_o         <= '0;
            p_dst_id_o     <= '0;
            p_dst_rob_o    <= '0;
            p_src_rob_o    <= '0;
            p_src_data_o   <= '0;
            p_data_valid_o <= '0;
            p_check_o      <= '0;
            p_w_reg_o      <= '0;
        end else if (p_ready_i) begin   // hold under back-pressure
            p_slot_valid_o <= d_slot_valid_i;
            p_pc_o         <= d_pc_i;
            p_op_o         <= d_op_i;
            p_dst_id_o     <= d_dst_id_i;
            p_dst_rob_o    <= rob_id_i;
            p_src_rob_o    <= src_rob;
            p_src_data_o   <= src_data_i;
            p_data_valid_o <= src_ready;
            p_check_o      <= new_check_i;
            p_w_reg_o      <= d_w_reg_i;
        end
    end

endmodule

// ==== hdl/rename_top.sv ====
module rename_top import rename_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_i,
    // decode side
    input  logic                               d_valid_i,
    input  logic [N_DST-1:0]                   d_slot_valid_i,
    input  logic [DATA_W-1:0]                  d_pc_i,
    input  logic [OP_W-1:0]                    d_op_i,
    input  logic [N_SRC-1:0][ARF_ID_W-1:0]     d_src_id_i,
    input  logic [N_DST-1:0][ARF_ID_W-1:0]     d_dst_id_i,
    input  logic [N_DST-1:0]                   d_w_reg_i,
    input  logic [N_SRC-1:0]                   d_reg_need_i,
    output logic                               d_ready_o,
    // retire side
    input  logic                               c_flush_i,
    input  logic [N_DST-1:0]                   c_retire_i,
    input  logic [N_DST-1:0]                   c_w_valid_i,
    input  logic [N_DST-1:0][ARF_ID_W-1:0]     c_arf_id_i,
    input  logic [N_DST-1:0][ROB_ID_W-1:0]     c_rob_id_i,
    input  logic [N_DST-1:0]                   c_check_i,
    input  logic [N_DST-1:0][DATA_W-1:0]       c_data_i,
    // dispatch side
    input  logic                               p_ready_i,
    output logic                               p_valid_o,
    output logic [N_DST-1:0]                   p_slot_valid_o,
    output logic [DATA_W-1:0]                  p_pc_o,
    output logic [OP_W-1:0]                    p_op_o,
    output logic [N_DST-1:0][ARF_ID_W-1:0]     p_dst_id_o,
    output logic [N_DST-1:0][ROB_ID_W-1:0]     p_dst_rob_o,
    output logic [N_SRC-1:0][ROB_ID_W-1:0]     p_src_rob_o,
    output logic [N_SRC-1:0][DATA_W-1:0]       p_src_data_o,
    output logic [N_SRC-1:0]                   p_data_valid_o,
    output logic [N_DST-1:0]                   p_check_o,
    output logic [N_DST-1:0]                   p_w_reg_o
);

    logic       [N_DST-1:0]                issue;
    logic       [N_DST-1:0][ROB_ID_W-1:0]  rob_id;
    rat_entry_t [N_SRC-1:0]                src_map;
    rat_entry_t [N_SRC+N_DST-1:0]          commit_map;
    rat_entry_t [N_SRC-1:0]                commit_src_map;
    logic       [N_DST-1:0]                commit_dst_check;
    logic       [N_DST-1:0]                new_check;
    logic       [N_SRC-1:0][DATA_W-1:0]    src_data;

    // sources in the low ports, destinations above
    assign commit_src_map = commit_map[N_SRC-1:0];
    assign commit_dst_check = {commit_map[N_SRC+1].check, commit_map[N_SRC].check};

    rob_alloc u_rob_alloc (
        .clk            (clk),
        .rst_i          (rst_i),
        .c_flush_i      (c_flush_i),
        .d_valid_i      (d_valid_i),
        .d_slot_valid_i (d_slot_valid_i),
        .p_ready_i      (p_ready_i),
        .c_retire_i     (c_retire_i),
        .d_ready_o      (d_ready_o),
        .issue_o        (issue),
        .rob_id_o       (rob_id)
    );

    spec_rat u_spec_rat (
        .clk         (clk),
        .rst_i       (rst_i),
        .c_flush_i   (c_flush_i),
        .src_id_i    (d_src_id_i),
        .dst_id_i    (d_dst_id_i),
        .w_reg_i     (d_w_reg_i),
        .issue_i     (issue),
        .rob_id_i    (rob_id),
        .cw_check_i  (commit_dst_check),
        .src_map_o   (src_map),
        .new_check_o (new_check)
    );

    commit_rat u_commit_rat (
        .clk         (clk),
        .rst_i       (rst_i),
        .c_flush_i   (c_flush_i),
        .rd_id_i     ({d_dst_id_i, d_src_id_i}),
        .c_retire_i  (c_retire_i),
        .c_w_valid_i (c_w_valid_i),
        .c_arf_id_i  (c_arf_id_i),
        .c_rob_id_i  (c_rob_id_i),
        .c_check_i   (c_check_i),
        .rd_map_o    (commit_map)
    );

    arf u_arf (
        .clk         (clk),
        .rst_i       (rst_i),
        .rd_id_i     (d_src_id_i),
        .c_retire_i  (c_retire_i),
        .c_w_valid_i (c_w_valid_i),
        .c_arf_id_i  (c_arf_id_i),
        .c_data_i    (c_data_i),
        .rd_data_o   (src_data)
    );

    // slot valid taken from the issue strobes, idle cycles go out empty
    rename_out u_rename_out (
        .clk              (clk),
        .rst_i            (rst_i),
        .c_flush_i        (c_flush_i),
        .p_ready_i        (p_ready_i),
        .d_slot_valid_i   (issue),
        .d_pc_i           (d_pc_i),
        .d_op_i           (d_op_i),
        .d_dst_id_i       (d_dst_id_i),
        .d_w_reg_i        (d_w_reg_i),
        .d_reg_need_i     (d_reg_need_i),
        .rob_id_i         (rob_id),
        .src_map_i        (src_map),
        .commit_src_map_i (commit_src_map),
        .new_check_i      (new_check),
        .src_data_i       (src_data),
        .p_valid_o        (p_valid_o),
        .p_slot_valid_o   (p_slot_valid_o),
        .p_pc_o           (p_pc_o),
        .p_op_o           (p_op_o),
        .p_dst_id_o       (p_dst_id_o),
        .p_dst_rob_o      (p_dst_rob_o),
        .p_src_rob_o      (p_src_rob_o),
        .p_src_data_o     (p_src_data_o),
        .p_data_valid_o   (p_data_valid_o),
        .p_check_o        (p_check_o),
        .p_w_reg_o        (p_w_reg_o)
    );

endmodule

// ==== verif/tb_rename.sv ====
module tb_rename import rename_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [3:0]        tid;
        logic              dv;
        logic [1:0]        sv;
        logic [3:0][4:0]   src;
        logic [1:0][4:0]   dst;
        logic [1:0]        w;
        logic [3:0]        need;
        logic [1:0]        ret;
        logic [1:0]        wv;
        logic [1:0]        auto;   // take retire rob id and check from the model
        logic [1:0][4:0]   aid;
        logic [1:0][5:0]   crob;
        logic [1:0]        cchk;
        logic [1:0][31:0]  cdata;
        logic [31:0]       pc;
        logic [7:0]        op;
        logic              flush;
        logic              prdy;
    } row_t;

    logic clk = 1'b0;
    logic rst_i;
    logic d_valid_i, d_ready_o, c_flush_i, p_ready_i, p_valid_o;
    logic [1:0] d_slot_valid_i, d_w_reg_i, c_retire_i, c_w_valid_i, c_check_i;
    logic [31:0] d_pc_i, p_pc_o;
    logic [7:0] d_op_i, p_op_o;
    logic [3:0][4:0] d_src_id_i;
    logic [1:0][4:0] d_dst_id_i, c_arf_id_i, p_dst_id_o;
    logic [3:0] d_reg_need_i, p_data_valid_o;
    logic [1:0][5:0] c_rob_id_i, p_dst_rob_o;
    logic [1:0][31:0] c_data_i;
    logic [1:0] p_slot_valid_o, p_check_o, p_w_reg_o;
    logic [3:0][5:0] p_src_rob_o;
    logic [3:0][31:0] p_src_data_o;

    // reference model state
    logic [6:0]  spec_m [32];
    logic [6:0]  comm_m [32];
    logic [31:0] arf_m [32];
    int          cnt_m;
    logic [5:0]  ptr0_m, ptr1_m;
    logic        avail_m;
    // expected packet
    logic [1:0] e_sv, e_chk, e_w;
    logic [31:0] e_pc;
    logic [7:0] e_op;
    logic [1:0][4:0] e_dst;
    logic [1:0][5:0] e_drob;
    logic [3:0][5:0] e_srob;
    logic [3:0][31:0] e_sdata;
    logic [3:0] e_dv;

    row_t tbl[$];
    row_t cur;
    integer seed = 32'h70cfeb5e;
    int errors = 0, test_err = 0, tests = 0, failed = 0;
    int cycles = 0, limit = 100000;

    rename_top u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // slot 1 never reads slot 0's destination
    function automatic row_t keep_slots_apart(input row_t r);
        for (int k = 2; k < 4; k++) begin
            if (r.src[k] == r.dst[0]) begin
                r.src[k] = r.dst[0] + 5'd1;
            end
        end
        return r;
    endfunction

    function automatic row_t new_bundle(input logic [3:0] tid);
        row_t r;
        r = '0;
        r.tid = tid;
        r.dv = 1'b1;
        r.sv = 2'b11;
        r.w = 2'b11;
        r.prdy = 1'b1;
        r.need = 4'hf;
        r.pc = $random(seed);
        r.op = 8'($random(seed));
        for (int k = 0; k < 4; k++) r.src[k] = 5'($random(seed));
        r.dst[0] = 5'($random(seed)) | 5'd1;
        r.dst[1] = 5'($random(seed)) | 5'd1;
        return keep_slots_apart(r);
    endfunction

    task automatic build_table();
        row_t r;
        for (int n = 0; n < 3; n++) tbl.push_back(new_bundle(1));
        r = new_bundle(2);
        r.sv = 2'b01;
        r.w = 2'b01;
        r.dst[0] = 5'd5;
        tbl.push_back(keep_slots_apart(r));
        r = new_bundle(2);
        r.src[0] = 5'd5;
        r.src[1] = 5'd5;
        r.need = 4'b1101;   // src1 not needed
        r.dst = {5'd7, 5'd6};
        tbl.push_back(keep_slots_apart(r));
        r = new_bundle(3);
        r.src[0] = 5'd5;
        r.src[1] = 5'd0;
        r.dst = {5'd9, 5'd8};
        r.ret = 2'b11;
        r.wv = 2'b11;
        r.auto = 2'b01;
        r.aid = {5'd0, 5'd5};   // slot 1 aims at r0
        r.crob[1] = 6'd3;
        r.cchk[1] = 1'b1;
        r.cdata = {32'($random(seed)), 32'($random(seed))};
        tbl.push_back(keep_slots_apart(r));
        r = new_bundle(3);
        r.src[0] = 5'd5;
        r.src[1] = 5'd0;
        r.dst = {5'd11, 5'd10};
        tbl.push_back(keep_slots_apart(r));
        for (int n = 0; n < 3; n++) begin
            r = new_bundle(4);
            r.prdy = (n == 2);
            tbl.push_back(r);
        end
        for (int n = 0; n < 34; n++) tbl.push_back(new_bundle(5));
        for (int n = 0; n < 8; n++) begin
            r = new_bundle(5);
            r.dv = 1'b0;
            r.ret = 2'b11;   // retire without register write
            tbl.push_back(r);
        end
        tbl.push_back(new_bundle(5));
        r = new_bundle(6);
        r.flush = 1'b1;
        tbl.push_back(r);
        for (int n = 0; n < 2; n++) begin
            r = new_bundle(6);
            r.src[0] = 5'd5;
            tbl.push_back(r);
        end
    endtask

    function automatic logic [6:0] comm_rd(input logic [4:0] id);
        logic [6:0] v;
        v = comm_m[id];
        for (int j = 0; j < 2; j++)
            if (cur.ret[j] && cur.wv[j] && cur.aid[j] != 0 && cur.aid[j] == id)
                v = {cur.cchk[j], cur.crob[j]};
        return v;
    endfunction

    function automatic logic [31:0] arf_rd(input logic [4:0] id);
        logic [31:0] v;
        v = arf_m[id];
        for (int j = 0; j < 2; j++)
            if (cur.ret[j] && cur.wv[j] && cur.aid[j] != 0 && cur.aid[j] == id)
                v = cur.cdata[j];
        if (id == 0) v = '0;
        return v;
    endfunction

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] got);
        if (exp !== got) begin
            $display("[ERROR] %s expected %0h got %0h", name, exp, got);
            errors++;
            test_err++;
        end
    endtask

    task automatic check_packet();
        check("p_valid_o", 1, p_valid_o);
        check("p_slot_valid_o", e_sv, p_slot_valid_o);
        check("p_pc_o", e_pc, p_pc_o);
        check("p_op_o", e_op, p_op_o);
        check("p_dst_id_o", e_dst, p_dst_id_o);
        check("p_dst_rob_o", e_drob, p_dst_rob_o);
        check("p_src_rob_o", e_srob, p_src_rob_o);
        check("p_src_data_o", e_sdata, p_src_data_o);
        check("p_data_valid_o", e_dv, p_data_valid_o);
        check("p_check_o", e_chk, p_check_o);
        check("p_w_reg_o", e_w, p_w_reg_o);
    endtask

    task automatic clear_state(input logic with_arf);
        for (int r = 0; r < 32; r++) begin
            spec_m[r] = '0;
            comm_m[r] = '0;
            if (with_arf) arf_m[r] = '0;
        end
        cnt_m = 0;
        ptr0_m = 6'd0;
        ptr1_m = 6'd1;
        avail_m = 1'b1;
        {e_sv, e_chk, e_w, e_pc, e_op, e_dst, e_drob, e_srob, e_sdata, e_dv} = '0;
    endtask

    // one clock of the model with the inputs of cur already on the pins
    task automatic step_model();
        logic rdy;
        logic [1:0] iss, newchk;
        logic [6:0] cm;
        int ni;
        rdy = avail_m & ~cur.flush & cur.prdy;
        check("d_ready_o", rdy, d_ready_o);
        iss = cur.sv & {2{cur.dv & rdy}};
        ni = int'(iss[0]) + int'(iss[1]);
        for (int k = 0; k < 2; k++) begin
            cm = comm_rd(cur.dst[k]);
            newchk[k] = ~cm[6];
        end
        if (!cur.flush && cur.prdy) begin
            e_sv = iss;
            e_pc = cur.pc;
            e_op = cur.op;
            e_dst = cur.dst;
            e_drob = {ptr1_m, ptr0_m};
            e_chk = newchk;
            e_w = cur.w;
            for (int k = 0; k < 4; k++) begin
                e_srob[k] = spec_m[cur.src[k]][5:0];
                e_sdata[k] = arf_rd(cur.src[k]);
                e_dv[k] = ~cur.need[k] | (spec_m[cur.src[k]] == comm_rd(cur.src[k]));
            end
        end
        for (int j = 0; j < 2; j++)   // arf keeps retire writes through a flush
            if (cur.ret[j] && cur.wv[j] && cur.aid[j] != 0) arf_m[cur.aid[j]] = cur.cdata[j];
        if (cur.flush) begin
            clear_state(1'b0);
        end else begin
            avail_m = (cnt_m <= ROB_LIMIT);
            for (int k = 0; k < 2; k++)
                if (iss[k] && cur.w[k] && cur.dst[k] != 0)
                    spec_m[cur.dst[k]] = {newchk[k], (k == 0) ? ptr0_m : ptr1_m};
            for (int j = 0; j < 2; j++)
                if (cur.ret[j] && cur.wv[j] && cur.aid[j] != 0)
                    comm_m[cur.aid[j]] = {cur.cchk[j], cur.crob[j]};
            cnt_m = cnt_m + ni - int'(cur.ret[0]) - int'(cur.ret[1]);
            ptr0_m = ptr0_m + 6'(ni);
            ptr1_m = ptr1_m + 6'(ni);
        end
    endtask

    task automatic report_test(input logic [3:0] tid);
        tests++;
        if (test_err == 0) begin
            $display("test %0d passed", tid);
        end else begin
            $display("test %0d failed with %0d mismatches", tid, test_err);
            failed++;
        end
        test_err = 0;
    endtask

    task automatic drive(input row_t r);
        d_valid_i <= r.dv;
        d_slot_valid_i <= r.sv;
        d_pc_i <= r.pc;
        d_op_i <= r.op;
        d_src_id_i <= r.src;
        d_dst_id_i <= r.dst;
        d_w_reg_i <= r.w;
        d_reg_need_i <= r.need;
        c_retire_i <= r.ret;
        c_w_valid_i <= r.wv;
        c_arf_id_i <= r.aid;
        c_rob_id_i <= r.crob;
        c_check_i <= r.cchk;
        c_data_i <= r.cdata;
        c_flush_i <= r.flush;
        p_ready_i <= r.prdy;
    endtask

    initial begin
        rst_i = 1'b1;
        drive('0);
        build_table();
        limit = tbl.size() * 4 + 50;
        clear_state(1'b1);
        repeat (4) @(posedge clk);
        for (int i = 0; i < tbl.size(); i++) begin
            @(posedge clk);
            if (i == 0) rst_i <= 1'b0;   // fifth edge still sees reset
            cur = tbl[i];
            for (int k = 0; k < 2; k++) begin
                if (cur.auto[k]) begin
                    cur.crob[k] = spec_m[cur.aid[k]][5:0];
                    cur.cchk[k] = spec_m[cur.aid[k]][6];
                end
            end
            drive(cur);
            @(negedge clk);
            check_packet();
            if (i > 0 && tbl[i].tid != tbl[i-1].tid) report_test(tbl[i-1].tid);
            step_model();
        end
        @(negedge clk);
        check_packet();
        report_test(tbl[tbl.size()-1].tid);
        $display("%0d tests, %0d failed, %0d mismatches", tests, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
common/rename_pkg.sv
hdl/rob_alloc.sv
rename/spec_rat.sv
rename/commit_rat.sv
hdl/arf.sv
rename/rename_out.sv
hdl/rename_top.sv
verif/tb_rename.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module tb_rename -f sim.f -o tb_rename
	./obj_dir/tb_rename | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
